/* beat_counter.sv */
`timescale 1ns/1ns
`default_nettype none

module beat_counter (
   input  logic              clk,
   input  logic              rstn,
   input  logic              ar_fire,
   input  logic              r_fire,
   output color_pkg::beat_t  beat
);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         beat <= '0;
      end else if (ar_fire) begin
         beat <= '0;   // new burst
      end else if (r_fire) begin
         beat <= beat + 1'b1;
      end
   end

   // longest burst is the header, well short of 16 beats
   beat_no_wrap: assert property (@(posedge clk) disable iff (!rstn)
      r_fire && !ar_fire |-> beat != '1);

endmodule

`default_nettype wire

/* color_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none
`include "color_defines.svh"

module color_ctrl (
   input  logic                     clk,
   input  logic                     rstn,
   input  logic                     task_in_valid,
   output logic                     task_in_ready,
   input  color_pkg::task_t         task_in,
   output logic                     task_out_valid,
   input  logic                     task_out_ready,
   output color_pkg::task_t         task_out,
   output logic                     ar_valid,
   input  logic                     ar_ready,
   output color_pkg::mem_ar_t       ar,
   input  logic                     r_valid,
   output logic                     r_ready,
   input  color_pkg::mem_r_t        r,
   output logic                     aw_valid,
   input  logic                     aw_ready,
   output color_pkg::mem_aw_t       aw,
   output logic                     w_valid,
   input  logic                     w_ready,
   output color_pkg::mem_w_t        w,
   output logic                     done,
   input  color_pkg::beat_t         beat,
   input  logic                     hdr_valid,
   input  logic [`COLOR_ADDR_W-1:0] color_addr,
   input  logic [`COLOR_ADDR_W-1:0] cnt_addr,
   input  logic [`COLOR_ADDR_W-1:0] bmp_addr,
   input  logic [`COLOR_DATA_W-1:0] new_color,
   input  logic [`COLOR_DATA_W-1:0] cnt_wdata,
   input  logic [`COLOR_DATA_W-1:0] bmp_wdata,
   input  logic                     bit_already_set,
   input  logic                     counter_is_one,
   output logic                     hdr_capture,
   output logic                     ld_bitmap,
   output logic                     ld_scratch,
   output color_pkg::task_t         cur_task
);

   color_pkg::ctrl_state_e state;
   color_pkg::ctrl_state_e state_next;
   logic r_fire;
   logic first_wr;    // aw and w go out together
   logic aw_done;
   logic w_done;
   logic wr_both;

   assign task_in_ready = (state == color_pkg::IDLE);
   assign done          = (state == color_pkg::FINISH);
   assign r_ready       = (state == color_pkg::WAIT_HEADERS) ||
                          (state == color_pkg::COLOR_WAIT_BITMAP) ||
                          (state == color_pkg::RECV_WAIT_SCRATCH);
   assign r_fire        = r_valid && r_ready;
   assign hdr_capture   = r_fire && (state == color_pkg::WAIT_HEADERS);
   assign ld_bitmap     = r_fire && (state == color_pkg::COLOR_WAIT_BITMAP);
   assign ld_scratch    = r_fire && (state == color_pkg::RECV_WAIT_SCRATCH);

   assign first_wr = (state == color_pkg::COLOR_WRITE) ||
                     (state == color_pkg::RECV_WRITE_COUNTER);
   assign wr_both  = (aw_done || aw_ready) && (w_done || w_ready);

   always_ff @(posedge clk) begin
      if (task_in_valid && task_in_ready) begin
         cur_task <= task_in;
      end
   end

   // remember which half of the first write already went
   always_ff @(posedge clk) begin
      if (!rstn) begin
         aw_done <= 1'b0;
         w_done  <= 1'b0;
      end else if (first_wr && !wr_both) begin
         aw_done <= aw_done || aw_ready;
         w_done  <= w_done || w_ready;
      end else begin
         aw_done <= 1'b0;
         w_done  <= 1'b0;
      end
   end

   always_comb begin
      state_next     = state;
      ar_valid       = 1'b0;
      ar             = '0;
      aw_valid       = 1'b0;
      aw             = '0;
      w_valid        = 1'b0;
      w              = '0;
      task_out_valid = 1'b0;
      task_out       = '0;
      case (state)
         color_pkg::IDLE: begin
            if (task_in_valid) begin
               state_next = hdr_valid ? color_pkg::DISPATCH : color_pkg::READ_HEADERS;
            end
         end
         color_pkg::READ_HEADERS: begin
            ar_valid = 1'b1;
            ar.len   = 8'(`COLOR_HDR_LEN);   // header sits at address 0
            if (ar_ready) state_next = color_pkg::WAIT_HEADERS;
         end
         color_pkg::WAIT_HEADERS: begin
            if (r_fire && r.last) state_next = color_pkg::DISPATCH;
         end
         color_pkg::DISPATCH: begin
            case (cur_task.ttype)
               color_pkg::COLOR_TASK:   state_next = color_pkg::COLOR_READ_BITMAP;
               color_pkg::RECEIVE_TASK: state_next = color_pkg::RECV_READ_SCRATCH;
               default:                 state_next = color_pkg::FINISH;
            endcase
         end
         color_pkg::COLOR_READ_BITMAP: begin
            ar_valid = 1'b1;
            ar.addr  = bmp_addr;
            if (ar_ready) state_next = color_pkg::COLOR_WAIT_BITMAP;
         end
         color_pkg::COLOR_WAIT_BITMAP: begin
            if (r_fire && r.last) state_next = color_pkg::COLOR_WRITE;
         end
         color_pkg::COLOR_WRITE: begin
            aw_valid = !aw_done;
            aw.addr  = color_addr;
            w_valid  = !w_done;
            w.data   = new_color;
            w.last   = 1'b1;
            if (wr_both) state_next = color_pkg::FINISH;
         end
         color_pkg::RECV_READ_SCRATCH: begin
            ar_valid = 1'b1;
            ar.addr  = cnt_addr;
            ar.len   = 8'd1;   // counter then bitmap
            if (ar_ready) state_next = color_pkg::RECV_WAIT_SCRATCH;
         end
         color_pkg::RECV_WAIT_SCRATCH: begin
            if (r_fire && r.last) state_next = color_pkg::RECV_WRITE_COUNTER;
         end
         color_pkg::RECV_WRITE_COUNTER: begin
            aw_valid = !aw_done;
            aw.addr  = cnt_addr;
            aw.len   = bit_already_set ? 8'd0 : 8'd1;
            w_valid  = !w_done;
            w.data   = cnt_wdata;
            w.last   = bit_already_set;
            if (wr_both) begin
               if (!bit_already_set) begin
                  state_next = color_pkg::RECV_WRITE_BITMAP;
               end else begin
                  state_next = counter_is_one ? color_pkg::RECV_ENQ_COLOR : color_pkg::FINISH;
               end
            end
         end
         color_pkg::RECV_WRITE_BITMAP: begin
            w_valid = 1'b1;
            w.data  = bmp_wdata;
            w.last  = 1'b1;
            if (w_ready) begin
               state_next = counter_is_one ? color_pkg::RECV_ENQ_COLOR : color_pkg::FINISH;
            end
         end
         color_pkg::RECV_ENQ_COLOR: begin
            task_out_valid = 1'b1;
            task_out.ttype = color_pkg::COLOR_TASK;
            task_out.locale = cur_task.locale;   // args stay zero
            if (task_out_ready) state_next = color_pkg::FINISH;
         end
         color_pkg::FINISH: state_next = color_pkg::IDLE;
         default: state_next = color_pkg::IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= color_pkg::IDLE;
      end else begin
         state <= state_next;
      end
   end

   ar_hold: assert property (@(posedge clk) disable iff (!rstn)
      ar_valid && !ar_ready |=> ar_valid && $stable(ar));
   aw_hold: assert property (@(posedge clk) disable iff (!rstn)
      aw_valid && !aw_ready |=> aw_valid && $stable(aw));
   task_out_hold: assert property (@(posedge clk) disable iff (!rstn)
      task_out_valid && !task_out_ready |=> task_out_valid && $stable(task_out));

   // memory ends each burst on the beat the request asked for
   burst_len_match: assert property (@(posedge clk) disable iff (!rstn)
      r_fire && r.last |->
         beat == ((state == color_pkg::WAIT_HEADERS) ? color_pkg::beat_t'(`COLOR_HDR_LEN) :
                  (state == color_pkg::RECV_WAIT_SCRATCH) ? color_pkg::beat_t'(1) :
                  color_pkg::beat_t'(0)));

endmodule

`default_nettype wire

/* color_defines.svh */
`ifndef COLOR_DEFINES_SVH
`define COLOR_DEFINES_SVH

// memory port and task widths
`define COLOR_ADDR_W   32
`define COLOR_DATA_W   32
`define COLOR_LOCALE_W 32
`define COLOR_ARGS_W   32

// header block at address 0, len 9 means ten words
`define COLOR_HDR_LEN          9
`define COLOR_HDR_BEAT_COLOR   5
`define COLOR_HDR_BEAT_SCRATCH 7

// 8-byte scratch slot per vertex
`define COLOR_SCRATCH_CNT_OFS 0
`define COLOR_SCRATCH_BMP_OFS 4

// no free color left in the bitmap
`define COLOR_ALL_TAKEN 32

`endif

/* color_pkg.sv */
`default_nettype none
`include "color_defines.svh"

package color_pkg;

   // other encodings finish without memory traffic
   typedef enum logic [1:0] {
      COLOR_TASK   = 2'd2,
      RECEIVE_TASK = 2'd3
   } task_type_e;

   typedef struct packed {
      task_type_e                 ttype;
      logic [`COLOR_LOCALE_W-1:0] locale;
      logic [`COLOR_ARGS_W-1:0]   args;
   } task_t;

   typedef struct packed {
      logic [`COLOR_ADDR_W-1:0] addr;
      logic [7:0]               len;   // beats minus one
   } mem_ar_t;

   typedef struct packed {
      logic [`COLOR_DATA_W-1:0] data;
      logic                     last;
   } mem_r_t;

   typedef struct packed {
      logic [`COLOR_ADDR_W-1:0] addr;
      logic [7:0]               len;
   } mem_aw_t;

   typedef struct packed {
      logic [`COLOR_DATA_W-1:0] data;
      logic                     last;
   } mem_w_t;

   typedef logic [3:0] beat_t;

   typedef enum logic [3:0] {
      IDLE,
      READ_HEADERS,
      WAIT_HEADERS,
      DISPATCH,
      COLOR_READ_BITMAP,
      COLOR_WAIT_BITMAP,
      COLOR_WRITE,
      RECV_READ_SCRATCH,
      RECV_WAIT_SCRATCH,
      RECV_WRITE_COUNTER,
      RECV_WRITE_BITMAP,
      RECV_ENQ_COLOR,
      FINISH
   } ctrl_state_e;

endpackage

`default_nettype wire

/* color_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module color_tb;

   localparam int num_rows       = 10;
   localparam int timeout_cycles = 500;
   localparam logic [31:0] base_color_word   = 32'h0000_0100;
   localparam logic [31:0] base_scratch_word = 32'h0000_0200;

   typedef struct packed {
      logic [1:0]  ttype;
      logic [31:0] locale;
      logic [4:0]  rcolor;
      logic [31:0] cnt;
      logic [31:0] bmp;
      logic [31:0] exp_word;    // color, or counter minus one
      logic        exp_bmp_wr;
      logic [31:0] exp_bmp;
      logic        exp_task;
   } row_t;

   logic               clk;
   logic               rstn;
   logic               task_in_valid;
   logic               task_in_ready;
   color_pkg::task_t   task_in;
   logic               task_out_valid;
   logic               task_out_ready;
   color_pkg::task_t   task_out;
   logic               ar_valid;
   logic               ar_ready;
   color_pkg::mem_ar_t ar;
   logic               r_valid;
   logic               r_ready;
   color_pkg::mem_r_t  r;
   logic               aw_valid;
   logic               aw_ready;
   color_pkg::mem_aw_t aw;
   logic               w_valid;
   logic               w_ready;
   color_pkg::mem_w_t  w;
   logic               done;

   row_t               rows [num_rows];
   color_pkg::mem_ar_t ar_log [$];
   color_pkg::mem_aw_t aw_log [$];
   color_pkg::mem_w_t  w_log [$];
   color_pkg::task_t   tout_log [$];
   logic               tout_stalled = 1'b0;
   color_pkg::task_t   tout_held;

   tb_clkgen u_clk (.clk(clk), .rstn(rstn));

   mem_model u_mem (
      .clk(clk), .rstn(rstn),
      .ar_valid(ar_valid), .ar_ready(ar_ready), .ar(ar),
      .r_valid(r_valid), .r_ready(r_ready), .r(r),
      .aw_ready(aw_ready),
      .w_ready(w_ready),
      .task_out_ready(task_out_ready)
   );

   color_top UUT (
      .clk(clk), .rstn(rstn),
      .task_in_valid(task_in_valid), .task_in_ready(task_in_ready), .task_in(task_in),
      .task_out_valid(task_out_valid), .task_out_ready(task_out_ready), .task_out(task_out),
      .ar_valid(ar_valid), .ar_ready(ar_ready), .ar(ar),
      .r_valid(r_valid), .r_ready(r_ready), .r(r),
      .aw_valid(aw_valid), .aw_ready(aw_ready), .aw(aw),
      .w_valid(w_valid), .w_ready(w_ready), .w(w),
      .done(done)
   );

   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("RESULT: FAIL");
      $fatal(1, "testbench stopped on first error");
   endtask

   task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) fail_now($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_addr(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) fail_now($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_task(input string name, input color_pkg::task_t exp,
                             input color_pkg::task_t act);
      if (act !== exp) fail_now($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
   endtask

   // handshake log, plus hold check on the task output
   always @(posedge clk) begin
      if (rstn) begin
         if (ar_valid && ar_ready) ar_log.push_back(ar);
         if (aw_valid && aw_ready) aw_log.push_back(aw);
         if (w_valid && w_ready) w_log.push_back(w);
         if (task_out_valid && task_out_ready) tout_log.push_back(task_out);
         if (tout_stalled && (!task_out_valid || task_out !== tout_held))
            fail_now("task output was dropped or changed before it was accepted");
         tout_stalled = task_out_valid && !task_out_ready;
         tout_held    = task_out;
      end
   end

   task automatic fill_table();
      //          type  locale  color  counter bitmap        word    bmp_wr bitmap out  task
      rows[0] = '{2'd2, 32'd3, 5'd0,  32'd0, 32'h0000_0000, 32'd0,  1'b0, 32'h0,          1'b0};
      rows[1] = '{2'd2, 32'd7, 5'd0,  32'd0, 32'hffff_ffff, 32'd32, 1'b0, 32'h0,          1'b0};
      rows[2] = '{2'd2, 32'd1, 5'd0,  32'd0, 32'h0000_00b7, 32'd3,  1'b0, 32'h0,          1'b0};
      rows[3] = '{2'd3, 32'd2, 5'd5,  32'd4, 32'h0000_0003, 32'd3,  1'b1, 32'h0000_0023, 1'b0};
      rows[4] = '{2'd3, 32'd4, 5'd1,  32'd3, 32'h0000_0002, 32'd2,  1'b0, 32'h0,          1'b0};
      rows[5] = '{2'd3, 32'd5, 5'd31, 32'd1, 32'h0000_0001, 32'd0,  1'b1, 32'h8000_0001, 1'b1};
      rows[6] = '{2'd3, 32'd6, 5'd0,  32'd1, 32'h0000_0001, 32'd0,  1'b0, 32'h0,          1'b1};
      rows[7] = '{2'd0, 32'd9, 5'd0,  32'd5, 32'h0000_0000, 32'd0,  1'b0, 32'h0,          1'b0};
      rows[8] = '{2'd2, 32'd0, 5'd0,  32'd0, 32'h7fff_ffff, 32'd31, 1'b0, 32'h0,          1'b0};
      rows[9] = '{2'd1, 32'd8, 5'd3,  32'd2, 32'h0000_0000, 32'd0,  1'b0, 32'h0,          1'b0};
   endtask

   task automatic send_task(input color_pkg::task_t t, input string tag);
      int n;
      n = 0;
      @(posedge clk);
      #1;
      task_in       = t;
      task_in_valid = 1'b1;
      @(posedge clk);
      while (!task_in_ready) begin
         n++;
         if (n > timeout_cycles) fail_now({tag, ": task was never accepted"});
         @(posedge clk);
      end
      #1;
      task_in_valid = 1'b0;
      task_in       = '0;
   endtask

   task automatic wait_done(input string tag);
      int n;
      n = 0;
      @(posedge clk);
      while (!done) begin
         n++;
         if (n > timeout_cycles) fail_now({tag, ": done never pulsed"});
         @(posedge clk);
      end
   endtask

   task automatic run_row(input int i);
      row_t             row;
      string            tag;
      color_pkg::task_t t;
      color_pkg::task_t exp_task;
      logic [31:0]      color_byte;
      logic [31:0]      cnt_byte;
      logic             is_color;
      logic             is_recv;
      int               hdr;
      int               n_aw;
      int               n_w;
      row        = rows[i];
      tag        = $sformatf("row %0d", i);
      is_color   = (row.ttype == 2'd2);
      is_recv    = (row.ttype == 2'd3);
      color_byte = (base_color_word << 2) + (row.locale << 2);
      cnt_byte   = (base_scratch_word << 2) + (row.locale << 3);
      u_mem.mem[cnt_byte[11:2]]         = row.cnt;
      u_mem.mem[cnt_byte[11:2] + 10'd1] = row.bmp;
      ar_log.delete();
      aw_log.delete();
      w_log.delete();
      tout_log.delete();
      t.ttype  = color_pkg::task_type_e'(row.ttype);
      t.locale = row.locale;
      t.args   = {27'd0, row.rcolor};
      send_task(t, tag);
      wait_done(tag);

      // header burst only ahead of the very first task
      hdr = (i == 0) ? 1 : 0;
      check_word({tag, " read count"}, 32'(hdr + ((is_color || is_recv) ? 1 : 0)),
                 32'(ar_log.size()));
      if (hdr == 1) begin
         check_addr({tag, " header read addr"}, 32'h0, ar_log[0].addr);
         check_word({tag, " header read len"}, 32'd9, 32'(ar_log[0].len));
      end
      if (is_color || is_recv) begin
         check_addr({tag, " data read addr"}, is_color ? cnt_byte + 32'd4 : cnt_byte,
                    ar_log[hdr].addr);
         check_word({tag, " data read len"}, is_color ? 32'd0 : 32'd1, 32'(ar_log[hdr].len));
      end

      n_aw = (is_color || is_recv) ? 1 : 0;
      n_w  = is_color ? 1 : (is_recv ? 1 + int'(row.exp_bmp_wr) : 0);
      check_word({tag, " write request count"}, 32'(n_aw), 32'(aw_log.size()));
      check_word({tag, " write beat count"}, 32'(n_w), 32'(w_log.size()));
      if (n_aw == 1) begin
         check_addr({tag, " write addr"}, is_color ? color_byte : cnt_byte, aw_log[0].addr);
         check_word({tag, " write len"}, 32'(row.exp_bmp_wr), 32'(aw_log[0].len));
         check_word({tag, " first write data"}, row.exp_word, w_log[0].data);
         check_word({tag, " first write last"}, 32'(n_w == 1), 32'(w_log[0].last));
      end
      if (n_w == 2) begin
         check_word({tag, " bitmap write data"}, row.exp_bmp, w_log[1].data);
         check_word({tag, " bitmap write last"}, 32'd1, 32'(w_log[1].last));
      end

      check_word({tag, " output task count"}, 32'(row.exp_task), 32'(tout_log.size()));
      if (row.exp_task) begin
         exp_task.ttype  = color_pkg::COLOR_TASK;
         exp_task.locale = row.locale;
         exp_task.args   = '0;
         check_task({tag, " output task"}, exp_task, tout_log[0]);
      end
   endtask

   initial begin
      int n;
      task_in_valid = 1'b0;
      task_in       = '0;
      n             = 0;
      fill_table();
      for (int a = 0; a < 1024; a++) begin
         u_mem.mem[a] = {a[15:0] ^ 16'h5a3c, a[15:0]};
      end
      u_mem.mem[5] = base_color_word;
      u_mem.mem[7] = base_scratch_word;
      while (rstn !== 1'b1) begin
         n++;
         if (n > timeout_cycles) fail_now("reset never released");
         @(posedge clk);
      end
      @(posedge clk);
      // ready high, everything else low
      check_word("outputs after reset", 32'h40,
                 {25'd0, task_in_ready, ar_valid, aw_valid, w_valid, task_out_valid,
                  done, r_ready});
      for (int i = 0; i < num_rows; i++) begin
         run_row(i);
      end
      $display("RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

/* color_top.sv */
`timescale 1ns/1ns
`default_nettype none
`include "color_defines.svh"

module color_top (
   input  logic               clk,
   input  logic               rstn,
   input  logic               task_in_valid,
   output logic               task_in_ready,
   input  color_pkg::task_t   task_in,
   output logic               task_out_valid,
   input  logic               task_out_ready,
   output color_pkg::task_t   task_out,
   output logic               ar_valid,
   input  logic               ar_ready,
   output color_pkg::mem_ar_t ar,
   input  logic               r_valid,
   output logic               r_ready,
   input  color_pkg::mem_r_t  r,
   output logic               aw_valid,
   input  logic               aw_ready,
   output color_pkg::mem_aw_t aw,
   output logic               w_valid,
   input  logic               w_ready,
   output color_pkg::mem_w_t  w,
   output logic               done
);

   color_pkg::beat_t         beat;
   color_pkg::task_t         cur_task;
   logic                     hdr_valid;
   logic                     hdr_capture;
   logic                     ld_bitmap;
   logic                     ld_scratch;
   logic [`COLOR_ADDR_W-1:0] color_addr;
   logic [`COLOR_ADDR_W-1:0] cnt_addr;
   logic [`COLOR_ADDR_W-1:0] bmp_addr;
   logic [`COLOR_DATA_W-1:0] new_color;
   logic [`COLOR_DATA_W-1:0] cnt_wdata;
   logic [`COLOR_DATA_W-1:0] bmp_wdata;
   logic                     bit_already_set;
   logic                     counter_is_one;

   color_ctrl u_ctrl (
      .clk             (clk),
      .rstn            (rstn),
      .task_in_valid   (task_in_valid),
      .task_in_ready   (task_in_ready),
      .task_in         (task_in),
      .task_out_valid  (task_out_valid),
      .task_out_ready  (task_out_ready),
      .task_out        (task_out),
      .ar_valid        (ar_valid),
      .ar_ready        (ar_ready),
      .ar              (ar),
      .r_valid         (r_valid),
      .r_ready         (r_ready),
      .r               (r),
      .aw_valid        (aw_valid),
      .aw_ready        (aw_ready),
      .aw              (aw),
      .w_valid         (w_valid),
      .w_ready         (w_ready),
      .w               (w),
      .done            (done),
      .beat            (beat),
      .hdr_valid       (hdr_valid),
      .color_addr      (color_addr),
      .cnt_addr        (cnt_addr),
      .bmp_addr        (bmp_addr),
      .new_color       (new_color),
      .cnt_wdata       (cnt_wdata),
      .bmp_wdata       (bmp_wdata),
      .bit_already_set (bit_already_set),
      .counter_is_one  (counter_is_one),
      .hdr_capture     (hdr_capture),
      .ld_bitmap       (ld_bitmap),
      .ld_scratch      (ld_scratch),
      .cur_task        (cur_task)
   );

   beat_counter u_beat (
      .clk     (clk),
      .rstn    (rstn),
      .ar_fire (ar_valid & ar_ready),
      .r_fire  (r_valid & r_ready),
      .beat    (beat)
   );

   graph_headers u_hdr (
      .clk         (clk),
      .rstn        (rstn),
      .hdr_capture (hdr_capture),
      .beat        (beat),
      .rdata       (r.data),
      .locale      (cur_task.locale),
      .hdr_valid   (hdr_valid),
      .color_addr  (color_addr),
      .cnt_addr    (cnt_addr),
      .bmp_addr    (bmp_addr)
   );

   scratch_datapath u_dp (
      .clk             (clk),
      .rstn            (rstn),
      .ld_bitmap       (ld_bitmap),
      .ld_scratch      (ld_scratch),
      .beat            (beat),
      .rdata           (r.data),
      .recv_color      (cur_task.args[4:0]),
      .new_color       (new_color),
      .cnt_wdata       (cnt_wdata),
      .bmp_wdata       (bmp_wdata),
      .bit_already_set (bit_already_set),
      .counter_is_one  (counter_is_one)
   );

endmodule

`default_nettype wire

/* graph_headers.sv */
`timescale 1ns/1ns
`default_nettype none
`include "color_defines.svh"

module graph_headers (
   input  logic                       clk,
   input  logic                       rstn,
   input  logic                       hdr_capture,
   input  color_pkg::beat_t           beat,
   input  logic [`COLOR_DATA_W-1:0]   rdata,
   input  logic [`COLOR_LOCALE_W-1:0] locale,
   output logic                       hdr_valid,
   output logic [`COLOR_ADDR_W-1:0]   color_addr,
   output logic [`COLOR_ADDR_W-1:0]   cnt_addr,
   output logic [`COLOR_ADDR_W-1:0]   bmp_addr
);

   logic [`COLOR_ADDR_W-1:0] base_color;
   logic [`COLOR_ADDR_W-1:0] base_scratch;
   logic [`COLOR_ADDR_W-1:0] slot_addr;

   // header holds word addresses
   always_ff @(posedge clk) begin
      if (hdr_capture) begin
         case (beat)
            color_pkg::beat_t'(`COLOR_HDR_BEAT_COLOR):   base_color   <= {rdata[29:0], 2'b00};
            color_pkg::beat_t'(`COLOR_HDR_BEAT_SCRATCH): base_scratch <= {rdata[29:0], 2'b00};
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         hdr_valid <= 1'b0;
      end else if (hdr_capture && beat == color_pkg::beat_t'(`COLOR_HDR_LEN)) begin
         hdr_valid <= 1'b1;   // sticky until reset
      end
   end

   assign color_addr = base_color + (`COLOR_ADDR_W'(locale) << 2);
   assign slot_addr  = base_scratch + (`COLOR_ADDR_W'(locale) << 3);
   assign cnt_addr   = slot_addr + `COLOR_ADDR_W'(`COLOR_SCRATCH_CNT_OFS);
   assign bmp_addr   = slot_addr + `COLOR_ADDR_W'(`COLOR_SCRATCH_BMP_OFS);

endmodule

`default_nettype wire

/* mem_model.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_model (
   input  logic               clk,
   input  logic               rstn,
   input  logic               ar_valid,
   output logic               ar_ready,
   input  color_pkg::mem_ar_t ar,
   output logic               r_valid,
   input  logic               r_ready,
   output color_pkg::mem_r_t  r,
   output logic               aw_ready,
   output logic               w_ready,
   output logic               task_out_ready
);

   logic [31:0]        mem [0:1023];   // byte address bits 11:2
   logic [31:0]        rnd;
   logic [9:0]         rd_ptr;
   int                 rd_left;
   logic               ar_fire;
   logic               r_fire;
   color_pkg::mem_ar_t ar_req;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   initial begin
      ar_ready       = 1'b0;
      r_valid        = 1'b0;
      r              = '0;
      aw_ready       = 1'b0;
      w_ready        = 1'b0;
      task_out_ready = 1'b0;
      rnd            = 32'h32a820d2;
      rd_ptr         = '0;
      rd_left        = 0;
   end

   always @(posedge clk) begin
      ar_fire = ar_valid && ar_ready;
      r_fire  = r_valid && r_ready;
      ar_req  = ar;   // request goes away right after the handshake
      #1;
      rnd = xorshift(rnd);
      if (!rstn) begin
         rd_left = 0;
      end else if (ar_fire) begin
         rd_ptr  = ar_req.addr[11:2];
         rd_left = int'(ar_req.len) + 1;
      end else if (r_fire) begin
         rd_ptr  = rd_ptr + 10'd1;
         rd_left = rd_left - 1;
      end
      r_valid        = (rd_left != 0);
      r.data         = mem[rd_ptr];
      r.last         = (rd_left == 1);
      ar_ready       = (rnd[1:0] != 2'b00);
      aw_ready       = (rnd[3:2] != 2'b00);
      w_ready        = (rnd[5:4] != 2'b00);
      task_out_ready = rnd[6];   // stalls about half the time
   end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# build and run the color engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module color_tb -o sim_color
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit $status
fi

./obj_dir/sim_color
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed with status $status"
fi
exit $status

/* scratch_datapath.sv */
`timescale 1ns/1ns
`default_nettype none
`include "color_defines.svh"

module scratch_datapath (
   input  logic                     clk,
   input  logic                     rstn,
   input  logic                     ld_bitmap,
   input  logic                     ld_scratch,
   input  color_pkg::beat_t         beat,
   input  logic [`COLOR_DATA_W-1:0] rdata,
   input  logic [4:0]               recv_color,
   output logic [`COLOR_DATA_W-1:0] new_color,
   output logic [`COLOR_DATA_W-1:0] cnt_wdata,
   output logic [`COLOR_DATA_W-1:0] bmp_wdata,
   output logic                     bit_already_set,
   output logic                     counter_is_one
);

   logic [`COLOR_DATA_W-1:0] join_counter;
   logic [31:0]              bitmap;

   always_ff @(posedge clk) begin
      if (ld_scratch) begin
         // counter word first, then bitmap
         if (beat == color_pkg::beat_t'(0)) begin
            join_counter <= rdata;
         end else if (beat == color_pkg::beat_t'(1)) begin
            bitmap <= rdata;
         end
      end else if (ld_bitmap) begin
         bitmap <= rdata;
      end
   end

   // lowest free color
   always_comb begin
      new_color = `COLOR_DATA_W'(`COLOR_ALL_TAKEN);
      for (int i = 31; i >= 0; i--) begin
         if (!bitmap[i]) begin
            new_color = `COLOR_DATA_W'(i);
         end
      end
   end

   assign cnt_wdata       = join_counter - 1'b1;
   assign bmp_wdata       = bitmap | (32'd1 << recv_color);
   assign bit_already_set = bitmap[recv_color];
   assign counter_is_one  = (join_counter == `COLOR_DATA_W'(1));

   // controller loads one kind of burst at a time
   ld_exclusive: assert property (@(posedge clk) disable iff (!rstn)
      !(ld_bitmap && ld_scratch));

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
color_pkg.sv
beat_counter.sv
graph_headers.sv
scratch_datapath.sv
color_ctrl.sv
color_top.sv
tb_clkgen.sv
mem_model.sv
color_tb.sv

/* tb_clkgen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen (
   output logic clk,
   output logic rstn
);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;   // 10 ns period
   end

   initial begin
      rstn = 1'b0;
      repeat (16) @(posedge clk);
      #1;
      rstn = 1'b1;
   end

endmodule

`default_nettype wire
